/* sources.f */
+incdir+.
nes_mem_pkg.sv
shared_ram.sv
mem_arbiter.sv
loader_stager.sv
backup_sector_engine.sv
joypad_serializer.sv
nes_memory_top.sv
tb_nes_memory.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory core simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
	--top-module tb_nes_memory -Mdir obj_dir -o sim_nes_memory > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/sim_nes_memory > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "Simulation exited with an error status"
	exit 1
fi

cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

/* tb_nes_memory.sv */
// ********************
// Memory core testbench
// ********************
`timescale 1ns/1ps
`include "nes_config.svh"

module tb_nes_memory import nes_mem_pkg::*; ();

	localparam int CLK_HALF = 20;
	localparam int RAM_SIZE = 1 << `NES_RAM_AW;
	// Rough cycle budget per test, doubled for the watchdog
	localparam int EST_CYCLES = 700 + 2500 + 6000 + 8000 + 600 + 400;

	logic clk, reset_nes;
	logic cpu_req_valid, ppu_req_valid, cpu_credit, ppu_credit;
	mem_req_t cpu_req, ppu_req;
	mem_rsp_t cpu_rsp, ppu_rsp;
	logic downloading, load_wr, load_ready, game_reset;
	logic [`NES_ADDR_W-1:0] load_addr;
	logic [`NES_DATA_W-1:0] load_data;
	logic img_mounted, save_req, sd_rd, sd_wr, sd_ack;
	logic [31:0] img_size, sd_lba;
	logic [`NES_SECTOR_AW-1:0] sd_buff_addr;
	logic sd_buff_wr, sd_buff_rd, sd_buff_din_valid, sd_buff_ready;
	logic [`NES_DATA_W-1:0] sd_buff_dout, sd_buff_din;
	logic joypad_strobe, joy_swap, joypad1_bit, joypad2_bit;
	logic [1:0] joypad_clock;
	joy_buttons_t joy_a, joy_b;

	// Memory model and per-port bookkeeping, index 0 = PPU, 1 = CPU
	logic [7:0] model [RAM_SIZE];
	logic       known [RAM_SIZE];
	mem_req_t   ring [2][8];
	int head [2], tail [2], cred [2];
	logic exp_pend [2], exp_known [2];
	logic [7:0] exp_data [2];
	int rst_cnt, hold_cycles;
	int err_cnt, tests_passed, tests_failed, err_mark;
	logic [31:0] rng_state;

	nes_memory_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic button_at(joy_buttons_t b, int k);
		case (k)
			0: return b.a;
			1: return b.b;
			2: return b.select;
			3: return b.start;
			4: return b.up;
			5: return b.down;
			6: return b.left;
			7: return b.right;
			default: return 1'b0; // Zeros after the eighth bit
		endcase
	endfunction

	task automatic step();
		@(posedge clk);
		#5;
	endtask

	task automatic fail_value(string msg);
		err_cnt++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	// Response, credit and game reset monitor
	always @(negedge clk) begin
		logic crd;
		mem_rsp_t r;
		mem_req_t q;
		if (!reset_nes) begin
			for (int p = 0; p < 2; p++) begin
				crd = p ? cpu_credit : ppu_credit;
				r = p ? cpu_rsp : ppu_rsp;
				if (exp_pend[p]) begin
					assert (r.valid) else fail_value($sformatf("port %0d response missing", p));
					if (exp_known[p])
						assert (r.rdata == exp_data[p]) else
							fail_value($sformatf("port %0d read %h, expected %h",
								p, r.rdata, exp_data[p]));
					exp_pend[p] = 1'b0;
				end else begin
					assert (!r.valid) else fail_value($sformatf("port %0d stray response", p));
				end
				if (crd) begin
					assert (head[p] != tail[p]) else begin
						err_cnt++;
						$display("Port %0d returned a credit with nothing outstanding", p);
					end
					q = ring[p][head[p] % 8];
					head[p]++;
					cred[p]++;
					assert (cred[p] <= `NES_PORT_CREDITS) else begin
						err_cnt++;
						$display("Port %0d credit count went above its limit", p);
					end
					if (q.we) begin
						model[q.addr[`NES_RAM_AW-1:0]] = q.wdata;
						known[q.addr[`NES_RAM_AW-1:0]] = 1'b1;
					end else begin
						exp_pend[p] = 1'b1;
						exp_known[p] = known[q.addr[`NES_RAM_AW-1:0]];
						exp_data[p] = model[q.addr[`NES_RAM_AW-1:0]];
					end
				end
			end
			assert (!load_wr || load_ready) else begin
				err_cnt++;
				$display("Loader write was pulsed while load_ready was low");
			end
			assert (!(sd_buff_wr || sd_buff_rd) || sd_buff_ready) else begin
				err_cnt++;
				$display("SD byte was strobed while sd_buff_ready was low");
			end
			assert (!(sd_rd || sd_wr) || sd_lba < 2) else
				fail_value($sformatf("sector %0d requested beyond image", sd_lba));
			assert (game_reset == (downloading || rst_cnt != 0)) else
				fail_value($sformatf("game_reset %b, hold count %0d", game_reset, rst_cnt));
		end
		if (downloading)
			hold_cycles = 0;
		else if (game_reset)
			hold_cycles++;
		if (reset_nes)
			rst_cnt = 0;
		else if (downloading)
			rst_cnt = `NES_DL_RESET_CYCLES;
		else if (load_ready && rst_cnt != 0)
			rst_cnt--;
	end

	task automatic issue(int p, logic we, logic [`NES_ADDR_W-1:0] addr, logic [7:0] data);
		mem_req_t q;
		q.addr = addr;
		q.we = we;
		q.wdata = data;
		while (cred[p] == 0)
			step();
		ring[p][tail[p] % 8] = q;
		tail[p]++;
		cred[p]--;
		if (p == 1) begin
			cpu_req = q;
			cpu_req_valid = 1'b1;
		end else begin
			ppu_req = q;
			ppu_req_valid = 1'b1;
		end
		step();
		if (p == 1)
			cpu_req_valid = 1'b0;
		else
			ppu_req_valid = 1'b0;
	endtask

	task automatic wait_idle(int p);
		while (head[p] != tail[p] || exp_pend[p])
			@(negedge clk);
		step();
	endtask

	task automatic random_traffic(int p, int n);
		logic [31:0] v;
		for (int i = 0; i < n; i++) begin
			v = lcg_next();
			issue(p, v[31], `NES_ADDR_W'(v[12:8]), v[7:0]); // Shared window of 32 bytes
		end
		wait_idle(p);
	endtask

	task automatic sd_sector(logic load, int exp_lba);
		logic [7:0] b;
		logic [31:0] v;
		int a;
		while (!(load ? sd_rd : sd_wr))
			step();
		assert (sd_lba == exp_lba) else
			fail_value($sformatf("sector %0d, expected %0d", sd_lba, exp_lba));
		for (int i = 0; i < `NES_SECTOR_BYTES; i++) begin
			a = `NES_SAVE_BASE + exp_lba * `NES_SECTOR_BYTES + i;
			while (!sd_buff_ready)
				step();
			sd_buff_addr = i[`NES_SECTOR_AW-1:0];
			if (load) begin
				v = lcg_next();
				b = v[15:8];
				sd_buff_dout = b;
				sd_buff_wr = 1'b1;
				model[a] = b;
				known[a] = 1'b1;
				step();
				sd_buff_wr = 1'b0;
			end else begin
				sd_buff_rd = 1'b1;
				step();
				sd_buff_rd = 1'b0;
				while (!sd_buff_din_valid)
					@(negedge clk);
				assert (sd_buff_din == model[a]) else
					fail_value($sformatf("save byte %0d is %h, expected %h",
						a, sd_buff_din, model[a]));
				step();
			end
		end
		while (!sd_buff_ready)
			step();
		sd_ack = 1'b1;
		step();
		sd_ack = 1'b0;
		step();
	endtask

	task automatic shift_check(logic swap);
		joy_buttons_t p1, p2;
		logic [31:0] v;
		v = lcg_next();
		joy_a = v[11:4];
		v = lcg_next();
		joy_b = v[11:4];
		joy_swap = swap;
		p1 = swap ? joy_b : joy_a;
		p2 = swap ? joy_a : joy_b;
		joypad_strobe = 1'b1;
		step();
		step();
		joypad_strobe = 1'b0;
		step();
		for (int k = 0; k < 10; k++) begin
			@(negedge clk);
			assert (joypad1_bit == button_at(p1, k) && joypad2_bit == button_at(p2, k)) else
				fail_value($sformatf("pad bit %0d is %b%b, expected %b%b", k, joypad1_bit,
					joypad2_bit, button_at(p1, k), button_at(p2, k)));
			step();
			joypad_clock = 2'b11;
			step();
			joypad_clock = 2'b00;
			step();
		end
	endtask

	task automatic end_test(string name);
		if (err_cnt == err_mark) begin
			tests_passed++;
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, err_cnt - err_mark);
		end
		err_mark = err_cnt;
	endtask

	initial begin
		#(EST_CYCLES * 2 * 2 * CLK_HALF);
		$display("Timeout: the run did not finish within the cycle budget");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [`NES_ADDR_W-1:0] addrs [16];
		logic [31:0] v;
		rng_state = 32'h353b7792;
		reset_nes = 1'b1;
		{cpu_req_valid, ppu_req_valid, cpu_req, ppu_req} = '0;
		{downloading, load_wr, load_addr, load_data} = '0;
		{img_mounted, img_size, save_req, sd_ack} = '0;
		{sd_buff_addr, sd_buff_wr, sd_buff_dout, sd_buff_rd} = '0;
		{joypad_strobe, joypad_clock, joy_a, joy_b, joy_swap} = '0;
		for (int i = 0; i < RAM_SIZE; i++) begin
			model[i] = 8'(i ^ (i >> 8)); // Never read unless known
			known[i] = 1'b0;
		end
		for (int p = 0; p < 2; p++) begin
			head[p] = 0;
			tail[p] = 0;
			cred[p] = `NES_PORT_CREDITS;
			exp_pend[p] = 1'b0;
			exp_known[p] = 1'b0;
		end
		{rst_cnt, hold_cycles, err_cnt, tests_passed, tests_failed, err_mark} = '0;
		repeat (4) @(posedge clk);
		#5 reset_nes = 1'b0;
		step();

		// Loader writes during a download, read back by the CPU
		downloading = 1'b1;
		for (int i = 0; i < 16; i++) begin
			v = lcg_next();
			addrs[i] = `NES_ADDR_W'(16'h0100 + i * 7);
			while (!load_ready)
				step();
			load_addr = addrs[i];
			load_data = v[15:8];
			load_wr = 1'b1;
			model[addrs[i][`NES_RAM_AW-1:0]] = v[15:8];
			known[addrs[i][`NES_RAM_AW-1:0]] = 1'b1;
			step();
			load_wr = 1'b0;
		end
		step();
		downloading = 1'b0;
		for (int i = 0; i < 16; i++)
			issue(1, 1'b0, addrs[i], 8'h00);
		wait_idle(1);
		end_test("loader_writes");

		fork
			random_traffic(0, 60);
			random_traffic(1, 60);
		join
		end_test("credits");

		while (game_reset)
			step();
		assert (hold_cycles == `NES_DL_RESET_CYCLES) else
			fail_value($sformatf("game_reset held %0d cycles", hold_cycles));
		end_test("game_reset");

		img_size = 32'd1024;
		img_mounted = 1'b1;
		step();
		img_mounted = 1'b0;
		sd_sector(1'b1, 0);
		sd_sector(1'b1, 1);
		repeat (20) step(); // No third sector may follow
		for (int i = 0; i < 24; i++) begin
			v = lcg_next();
			issue(1, 1'b0, `NES_ADDR_W'(`NES_SAVE_BASE + v[9:0]), 8'h00);
		end
		wait_idle(1);
		end_test("load_on_mount");

		for (int i = 0; i < 16; i++) begin
			v = lcg_next();
			issue(1, 1'b1, `NES_ADDR_W'(`NES_SAVE_BASE + v[9:0]), v[23:16]);
		end
		wait_idle(1);
		save_req = 1'b1;
		step();
		step();
		save_req = 1'b0;
		sd_sector(1'b0, 0);
		sd_sector(1'b0, 1);
		downloading = 1'b1;
		repeat (3) step();
		downloading = 1'b0;
		save_req = 1'b1;
		repeat (20) begin
			step();
			assert (!sd_wr && !sd_rd) else
				fail_value("transfer started with backup disabled");
		end
		save_req = 1'b0;
		end_test("save");

		while (game_reset)
			step();
		shift_check(1'b0);
		shift_check(1'b1);
		end_test("controller");

		$display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* nes_memory_top.sv */
// ********************
// NES memory top
// ********************
`timescale 1ns/1ps
`include "nes_config.svh"

module nes_memory_top import nes_mem_pkg::*; (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic                     cpu_req_valid,
	input  mem_req_t                 cpu_req,
	output logic                     cpu_credit,
	output mem_rsp_t                 cpu_rsp,
	input  logic                     ppu_req_valid,
	input  mem_req_t                 ppu_req,
	output logic                     ppu_credit,
	output mem_rsp_t                 ppu_rsp,
	input  logic                     downloading,
	input  logic                     load_wr,
	input  logic [`NES_ADDR_W-1:0]   load_addr,
	input  logic [`NES_DATA_W-1:0]   load_data,
	output logic                     load_ready,
	output logic                     game_reset,
	input  logic                     img_mounted,
	input  logic [31:0]              img_size,
	input  logic                     save_req,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic [31:0]              sd_lba,
	input  logic                     sd_ack,
	input  logic [`NES_SECTOR_AW-1:0] sd_buff_addr,
	input  logic                     sd_buff_wr,
	input  logic [`NES_DATA_W-1:0]   sd_buff_dout,
	input  logic                     sd_buff_rd,
	output logic [`NES_DATA_W-1:0]   sd_buff_din,
	output logic                     sd_buff_din_valid,
	output logic                     sd_buff_ready,
	input  logic                     joypad_strobe,
	input  logic [1:0]               joypad_clock,
	input  joy_buttons_t             joy_a,
	input  joy_buttons_t             joy_b,
	input  logic                     joy_swap,
	output logic                     joypad1_bit,
	output logic                     joypad2_bit
);

	logic     [3:0] arb_valid;
	mem_req_t [3:0] arb_req;
	logic     [3:0] arb_credit;
	mem_rsp_t [3:0] arb_rsp;
	logic           joy_reset;

	// Port order PPU 0, CPU 1, loader 2, backup 3
	assign arb_valid[0] = ppu_req_valid;
	assign arb_req[0] = ppu_req;
	assign arb_valid[1] = cpu_req_valid;
	assign arb_req[1] = cpu_req;
	assign ppu_credit = arb_credit[0];
	assign ppu_rsp = arb_rsp[0];
	assign cpu_credit = arb_credit[1];
	assign cpu_rsp = arb_rsp[1];

	assign joy_reset = reset_nes | game_reset; // Pads cleared during game reset

	mem_arbiter arb_i (
		.clk       (clk),
		.reset_nes (reset_nes),
		.req_valid (arb_valid),
		.req       (arb_req),
		.credit    (arb_credit),
		.rsp       (arb_rsp)
	);

	loader_stager loader_i (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.downloading (downloading),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.credit      (arb_credit[2]),
		.rsp         (arb_rsp[2]),
		.load_ready  (load_ready),
		.game_reset  (game_reset),
		.req_valid   (arb_valid[2]),
		.req         (arb_req[2])
	);

	backup_sector_engine backup_i (
		.clk               (clk),
		.reset_nes         (reset_nes),
		.downloading       (downloading),
		.img_mounted       (img_mounted),
		.img_size          (img_size),
		.save_req          (save_req),
		.sd_ack            (sd_ack),
		.sd_buff_addr      (sd_buff_addr),
		.sd_buff_wr        (sd_buff_wr),
		.sd_buff_dout      (sd_buff_dout),
		.sd_buff_rd        (sd_buff_rd),
		.credit            (arb_credit[3]),
		.rsp               (arb_rsp[3]),
		.sd_rd             (sd_rd),
		.sd_wr             (sd_wr),
		.sd_lba            (sd_lba),
		.sd_buff_din       (sd_buff_din),
		.sd_buff_din_valid (sd_buff_din_valid),
		.sd_buff_ready     (sd_buff_ready),
		.req_valid         (arb_valid[3]),
		.req               (arb_req[3])
	);

	joypad_serializer joy_i (
		.clk           (clk),
		.reset_nes     (joy_reset),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_swap      (joy_swap),
		.joypad1_bit   (joypad1_bit),
		.joypad2_bit   (joypad2_bit)
	);

endmodule

/* joypad_serializer.sv */
// ********************
// Controller ports
// ********************
`timescale 1ns/1ps
`include "nes_config.svh"

module joypad_serializer import nes_mem_pkg::*; (
	input  logic         clk,
	input  logic         reset_nes,
	input  logic         joypad_strobe,
	input  logic [1:0]   joypad_clock,
	input  joy_buttons_t joy_a,
	input  joy_buttons_t joy_b,
	input  logic         joy_swap,
	output logic         joypad1_bit,
	output logic         joypad2_bit
);

	logic [7:0] shreg [2];
	logic [7:0] load_val [2];
	logic [1:0] clock_d;

	// NES order, A leaves first from bit 0
	function automatic logic [7:0] nes_order(input joy_buttons_t btn);
		return {btn.right, btn.left, btn.down, btn.up,
			btn.start, btn.select, btn.b, btn.a};
	endfunction

	always_comb begin
		load_val[0] = nes_order(joy_swap ? joy_b : joy_a);
		load_val[1] = nes_order(joy_swap ? joy_a : joy_b);
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shreg[0] <= '0;
			shreg[1] <= '0;
			clock_d <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (joypad_strobe)
					shreg[i] <= load_val[i];           // Continuous reload
				else if (clock_d[i] && !joypad_clock[i])
					shreg[i] <= {1'b0, shreg[i][7:1]}; // Zeros fill in behind
			end
			clock_d <= joypad_clock;
		end
	end

	assign joypad1_bit = shreg[0][0];
	assign joypad2_bit = shreg[1][0];

endmodule

/* backup_sector_engine.sv */
// ********************
// Save RAM sector engine
// ********************
`timescale 1ns/1ps
`include "nes_config.svh"

module backup_sector_engine import nes_mem_pkg::*; (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic                     downloading,
	input  logic                     img_mounted,
	input  logic [31:0]              img_size,
	input  logic                     save_req,
	input  logic                     sd_ack,
	input  logic [`NES_SECTOR_AW-1:0] sd_buff_addr,
	input  logic                     sd_buff_wr,
	input  logic [`NES_DATA_W-1:0]   sd_buff_dout,
	input  logic                     sd_buff_rd,
	input  logic                     credit,
	input  mem_rsp_t                 rsp,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic [31:0]              sd_lba,
	output logic [`NES_DATA_W-1:0]   sd_buff_din,
	output logic                     sd_buff_din_valid,
	output logic                     sd_buff_ready,
	output logic                     req_valid,
	output mem_req_t                 req
);

	localparam int CRED_W = $clog2(`NES_PORT_CREDITS + 1);
	localparam int SECT_W = 32 - `NES_SECTOR_AW;

	logic                   bk_ena;     // Save RAM image present
	logic                   busy;
	logic                   loading;    // 1 = SD to memory
	logic [SECT_W-1:0]      sav_sectors;
	logic                   sd_ack_d;
	logic                   save_req_d;
	logic                   downloading_d;
	logic                   size_ok;
	logic                   start_load;
	logic                   start_save;

	logic [CRED_W-1:0]      cred;
	logic                   pend_valid;  // Byte waiting for credit
	logic                   rd_wait;     // Save byte waiting for its data
	mem_req_t               pend_req;
	logic [`NES_ADDR_W-1:0] byte_addr;

	assign size_ok = (img_size != '0) && (img_size[`NES_SECTOR_AW-1:0] == '0);
	assign start_load = img_mounted && size_ok && !busy;
	assign start_save = save_req && !save_req_d && bk_ena && !busy && !img_mounted;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			bk_ena <= 1'b0;
			busy <= 1'b0;
			loading <= 1'b0;
			sav_sectors <= '0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
			sd_lba <= '0;
			sd_ack_d <= 1'b0;
			save_req_d <= 1'b0;
			downloading_d <= 1'b0;
		end else begin
			sd_ack_d <= sd_ack;
			save_req_d <= save_req;
			downloading_d <= downloading;

			if (img_mounted && size_ok) begin
				bk_ena <= 1'b1;
				sav_sectors <= img_size[31:`NES_SECTOR_AW];
			end else if (img_mounted && img_size == '0) begin
				bk_ena <= 1'b0;
			end
			if (downloading && !downloading_d)
				bk_ena <= 1'b0;          // New game, old save no longer valid

			if (sd_ack && !sd_ack_d) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (start_load || start_save) begin
				busy <= 1'b1;
				loading <= start_load;
				sd_lba <= '0;
				sd_rd <= start_load;
				sd_wr <= start_save;
			end else if (busy && sd_ack_d && !sd_ack) begin
				if (sd_lba == 32'(sav_sectors) - 32'd1) begin
					busy <= 1'b0;        // Last sector done
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd <= loading;
					sd_wr <= !loading;
				end
			end
		end
	end

	// Sector byte to memory address
	assign byte_addr = `NES_ADDR_W'(`NES_SAVE_BASE)
		+ `NES_ADDR_W'(sd_lba * `NES_SECTOR_BYTES)
		+ `NES_ADDR_W'(sd_buff_addr);

	assign sd_buff_ready = !pend_valid && !rd_wait;
	assign req_valid = pend_valid && (cred != '0);
	assign req = pend_req;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			cred <= CRED_W'(`NES_PORT_CREDITS);
			pend_valid <= 1'b0;
			rd_wait <= 1'b0;
			sd_buff_din_valid <= 1'b0;
		end else begin
			cred <= cred + CRED_W'(credit) - CRED_W'(req_valid);
			if (sd_buff_wr || sd_buff_rd)
				pend_valid <= 1'b1;
			else if (req_valid)
				pend_valid <= 1'b0;
			if (sd_buff_rd)
				rd_wait <= 1'b1;
			else if (rsp.valid)
				rd_wait <= 1'b0;
			sd_buff_din_valid <= rsp.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sd_buff_wr || sd_buff_rd) begin
			pend_req.addr <= byte_addr;
			pend_req.we <= sd_buff_wr;
			pend_req.wdata <= sd_buff_dout;
		end
		if (rsp.valid)
			sd_buff_din <= rsp.rdata;  // Save byte back to the SD buffer
	end

endmodule

/* loader_stager.sv */
// ********************
// Loader write stager
// ********************
`timescale 1ns/1ps
`include "nes_config.svh"

module loader_stager import nes_mem_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   downloading,
	input  logic                   load_wr,
	input  logic [`NES_ADDR_W-1:0] load_addr,
	input  logic [`NES_DATA_W-1:0] load_data,
	input  logic                   credit,
	input  mem_rsp_t               rsp,      // Loader only writes, stays idle
	output logic                   load_ready,
	output logic                   game_reset,
	output logic                   req_valid,
	output mem_req_t               req
);

	localparam int CRED_W = $clog2(`NES_PORT_CREDITS + 1);
	localparam int RST_W = $clog2(`NES_DL_RESET_CYCLES + 1);

	logic [CRED_W-1:0] cred;
	logic              pend_valid;
	mem_req_t          pend_req;
	logic [RST_W-1:0]  rst_cnt;

	assign load_ready = !pend_valid;
	assign req_valid = pend_valid && (cred != '0);
	assign req = pend_req;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			cred <= CRED_W'(`NES_PORT_CREDITS);
			pend_valid <= 1'b0;
		end else begin
			cred <= cred + CRED_W'(credit) - CRED_W'(req_valid);
			if (load_wr)
				pend_valid <= 1'b1;
			else if (req_valid)
				pend_valid <= 1'b0;  // Handed to the arbiter
		end
	end

	always_ff @(posedge clk) begin
		if (load_wr) begin
			pend_req.addr <= load_addr;
			pend_req.we <= 1'b1;
			pend_req.wdata <= load_data;
		end
	end

	// Post-download reset hold, paused while a write waits
	always_ff @(posedge clk) begin
		if (reset_nes)
			rst_cnt <= '0;
		else if (downloading)
			rst_cnt <= RST_W'(`NES_DL_RESET_CYCLES);
		else if (!pend_valid && rst_cnt != '0)
			rst_cnt <= rst_cnt - 1'b1;
	end

	assign game_reset = downloading || (rst_cnt != '0);

endmodule

/* mem_arbiter.sv */
// ********************
// Memory arbiter
// ********************
`timescale 1ns/1ps
`include "nes_config.svh"

module mem_arbiter import nes_mem_pkg::*; (
	input  logic           clk,
	input  logic           reset_nes,
	input  logic     [3:0] req_valid,
	input  mem_req_t [3:0] req,
	output logic     [3:0] credit,
	output mem_rsp_t [3:0] rsp
);

	localparam int QCNT_W = $clog2(`NES_PORT_CREDITS + 1);

	// Two-entry queue per port
	mem_req_t          q_mem [4][2];
	logic              wr_ptr [4];
	logic              rd_ptr [4];
	logic [QCNT_W-1:0] q_cnt [4];

	logic       [1:0]  last_port;   // Last port granted
	logic              grant_any;
	logic       [1:0]  grant_port;
	mem_req_t          grant_req;

	logic              rd_pending;  // RAM data belongs to a read next cycle
	logic       [1:0]  rd_port;
	logic [`NES_DATA_W-1:0] rd_data;

	// Round-robin pick, starting after the last grant
	always_comb begin
		logic [1:0] idx;
		grant_any = 1'b0;
		grant_port = last_port;
		for (int i = 1; i <= 4; i++) begin
			idx = last_port + 2'(i);
			if (!grant_any && q_cnt[idx] != '0) begin
				grant_any = 1'b1;
				grant_port = idx;
			end
		end
		grant_req = q_mem[grant_port][rd_ptr[grant_port]];
	end

	always_comb begin
		credit = '0;
		if (grant_any)
			credit[grant_port] = 1'b1; // Served entry frees one credit
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			for (int p = 0; p < 4; p++) begin
				wr_ptr[p] <= 1'b0;
				rd_ptr[p] <= 1'b0;
				q_cnt[p] <= '0;
			end
			last_port <= 2'd3;      // Port 0 goes first
			rd_pending <= 1'b0;
			rd_port <= 2'd0;
		end else begin
			for (int p = 0; p < 4; p++) begin
				if (req_valid[p])
					wr_ptr[p] <= ~wr_ptr[p];
				if (credit[p])
					rd_ptr[p] <= ~rd_ptr[p];
				q_cnt[p] <= q_cnt[p] + QCNT_W'(req_valid[p]) - QCNT_W'(credit[p]);
			end
			if (grant_any)
				last_port <= grant_port;
			rd_pending <= grant_any && !grant_req.we;
			rd_port <= grant_port;
		end
	end

	// Queue storage
	always_ff @(posedge clk) begin
		for (int p = 0; p < 4; p++) begin
			if (req_valid[p])
				q_mem[p][wr_ptr[p]] <= req[p];
		end
	end

	shared_ram ram_i (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.grant_valid (grant_any),
		.grant_req   (grant_req),
		.rd_data     (rd_data)
	);

	// Steer the registered read byte back to its issuer
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			rsp[p].valid = rd_pending && (rd_port == 2'(p));
			rsp[p].rdata = rd_data;
		end
	end

endmodule

/* shared_ram.sv */
// ********************
// Shared RAM
// ********************
`timescale 1ns/1ps
`include "nes_config.svh"

module shared_ram import nes_mem_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   grant_valid,
	input  mem_req_t               grant_req,
	output logic [`NES_DATA_W-1:0] rd_data
);

	localparam int DEPTH = 1 << `NES_RAM_AW;

	logic [`NES_DATA_W-1:0] mem [DEPTH];
	logic [`NES_RAM_AW-1:0] ram_addr;

	assign ram_addr = grant_req.addr[`NES_RAM_AW-1:0]; // Upper bits ignored

	always_ff @(posedge clk) begin
		if (grant_valid && grant_req.we)
			mem[ram_addr] <= grant_req.wdata;
	end

	// Read byte shows up the cycle after the grant
	always_ff @(posedge clk) begin
		if (reset_nes)
			rd_data <= '0;
		else if (grant_valid && !grant_req.we)
			rd_data <= mem[ram_addr];
	end

endmodule

/* nes_mem_pkg.sv */
// ********************
// Memory subsystem types
// ********************
`include "nes_config.svh"

package nes_mem_pkg;

	// One memory access, read or write
	typedef struct packed {
		logic [`NES_ADDR_W-1:0] addr;
		logic                   we;    // 1 = write
		logic [`NES_DATA_W-1:0] wdata;
	} mem_req_t;

	// Read return, valid for one cycle per read
	typedef struct packed {
		logic                   valid;
		logic [`NES_DATA_W-1:0] rdata;
	} mem_rsp_t;

	// Controller buttons as the host reports them
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic a;
		logic b;
		logic select;
		logic start;
	} joy_buttons_t;

endpackage

/* nes_config.svh */
// ********************
// Memory core config
// ********************
`ifndef NES_CONFIG_SVH
`define NES_CONFIG_SVH

// Bus widths
`define NES_ADDR_W          22
`define NES_DATA_W          8

// Only the low address bits reach the on-chip RAM
`define NES_RAM_AW          14

// Queue depth per requester, also its credit count
`define NES_PORT_CREDITS    2

// Save RAM window and SD sector geometry
`define NES_SAVE_BASE       8192
`define NES_SECTOR_BYTES    512
`define NES_SECTOR_AW       9

// Game reset hold after the download ends
`define NES_DL_RESET_CYCLES 255

`endif
